// ==== hw/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  core_pkg::alu_op_e            op,
  input  logic [core_pkg::data_w-1:0]  a,
  input  logic [core_pkg::data_w-1:0]  b,
  output logic [core_pkg::data_w-1:0]  result,
  output core_pkg::flags_t             flags
);
  import core_pkg::*;

  logic [data_w:0] wide;  // extra bit catches carry out.
  logic            carry;
  logic            ovf;

  always_comb begin
    wide   = '0;
    carry  = 1'b0;
    ovf    = 1'b0;
    result = '0;

    case (op)
      alu_add: begin
        wide   = {1'b0, a} + {1'b0, b};
        result = wide[data_w-1:0];
        carry  = wide[data_w];
        ovf    = (a[data_w-1] == b[data_w-1]) && (result[data_w-1] != a[data_w-1]);
      end
      alu_sub, alu_cmp: begin
        wide   = {1'b0, a} - {1'b0, b};
        result = wide[data_w-1:0];
        carry  = wide[data_w];  // borrow.
        ovf    = (a[data_w-1] != b[data_w-1]) && (result[data_w-1] != a[data_w-1]);
      end
      alu_not:           result = ~a;
      alu_and, alu_test: result = a & b;
      alu_or:            result = a | b;
      alu_nand:          result = ~(a & b);
      alu_nor:           result = ~(a | b);
      alu_xor:           result = a ^ b;
      alu_mov:           result = b;
      alu_sar:           result = $signed(a) >>> b[3:0];
      alu_shr:           result = a >> b[3:0];
      alu_shl:           result = a << b[3:0];
      default:           result = '0;
    endcase

    flags.zero     = (result == '0);
    flags.sign     = result[data_w-1];
    flags.carry    = carry;
    flags.overflow = ovf;
  end

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        issue,
  input  core_pkg::jmp_op_e           jop,
  input  logic                        flag_write,
  input  core_pkg::flags_t            alu_flags,
  input  logic [core_pkg::data_w-1:0] target_imm,
  input  logic [core_pkg::data_w-1:0] rs_data,
  output logic [core_pkg::data_w-1:0] pc,
  output logic [core_pkg::data_w-1:0] next_pc,
  output logic                        taken,
  output core_pkg::flags_t            flags
);
  import core_pkg::*;

  flags_t            flags_q;
  logic [data_w-1:0] pc_q;
  logic [data_w-1:0] target;
  logic              less;

  // signed less-than from the flags before this instruction.
  assign less = flags_q.sign ^ flags_q.overflow;

  always_comb begin
    target = target_imm;
    case (jop)
      jmp_j:           taken = 1'b1;
      jmp_je, jmp_jz:  taken = flags_q.zero;
      jmp_jne, jmp_jnz: taken = !flags_q.zero;
      jmp_jl:          taken = less;
      jmp_jle:         taken = less || flags_q.zero;
      jmp_jg:          taken = !less && !flags_q.zero;
      jmp_jge:         taken = !less;
      jmp_jo:          taken = flags_q.overflow;
      jmp_jr: begin
        taken  = 1'b1;
        target = rs_data;  // register indirect.
      end
      default:         taken = 1'b0;
    endcase
  end

  assign pc      = pc_q;
  assign next_pc = taken ? target : pc_q + 1'b1;
  assign flags   = flag_write ? alu_flags : flags_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q    <= '0;
      flags_q <= '0;
    end else if (issue) begin
      pc_q <= next_pc;
      if (flag_write) begin
        flags_q <= alu_flags;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_unit (
  input  core_pkg::opcode_e opcode,
  output core_pkg::ctrl_t   ctrl
);
  import core_pkg::*;

  always_comb begin
    ctrl = '0;  // everything off, acts as nop.

    case (opcode)
      op_add, op_sub, op_not, op_and, op_or, op_nand, op_nor,
      op_mov, op_sar, op_shr, op_shl, op_xor, op_test, op_cmp: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_op_e'(opcode[3:0]);
      end
      op_addi, op_subi, op_noti, op_andi, op_ori, op_nandi, op_nori,
      op_movi, op_sari, op_shri, op_shli, op_xori, op_testi, op_cmpi: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_op_e'(opcode[3:0]);
      end
      op_lw, op_la: begin
        ctrl.alu_src     = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_op      = mem_read;
        ctrl.address_src = (opcode == op_la);
        ctrl.alu_op      = (opcode == op_la) ? alu_nop : alu_add;
      end
      op_sw, op_sa: begin
        ctrl.alu_src     = 1'b1;
        ctrl.mem_op      = mem_write;
        ctrl.address_src = (opcode == op_sa);
        ctrl.alu_op      = (opcode == op_sa) ? alu_nop : alu_add;
      end
      op_jmp: ctrl.jop = jmp_j;
      op_je:  ctrl.jop = jmp_je;
      op_jne: ctrl.jop = jmp_jne;
      op_jl:  ctrl.jop = jmp_jl;
      op_jle: ctrl.jop = jmp_jle;
      op_jg:  ctrl.jop = jmp_jg;
      op_jge: ctrl.jop = jmp_jge;
      op_jz:  ctrl.jop = jmp_jz;
      op_jnz: ctrl.jop = jmp_jnz;
      op_jo:  ctrl.jop = jmp_jo;
      op_jr:  ctrl.jop = jmp_jr;
      default: ctrl = '0;  // unknown opcode.
    endcase

    // compares only leave flags behind.
    if (ctrl.alu_op == alu_test || ctrl.alu_op == alu_cmp) begin
      ctrl.reg_write = 1'b0;
    end

    ctrl.flag_write = (ctrl.alu_op != alu_nop);
  end

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int data_w    = 16;
  localparam int reg_n     = 16;
  localparam int mem_depth = 256;
  localparam int credits   = 4;

  localparam int reg_idx_w  = $clog2(reg_n);
  localparam int mem_addr_w = $clog2(mem_depth);
  localparam int q_ptr_w    = $clog2(credits);
  localparam int q_cnt_w    = $clog2(credits + 1);

  // immediate forms reuse the low bits with prefix 01.
  typedef enum logic [5:0] {
    op_nop   = 6'b000000,
    op_add   = 6'b000001,
    op_sub   = 6'b000010,
    op_not   = 6'b000011,
    op_and   = 6'b000100,
    op_or    = 6'b000101,
    op_nand  = 6'b000110,
    op_nor   = 6'b000111,
    op_mov   = 6'b001000,
    op_sar   = 6'b001001,
    op_shr   = 6'b001010,
    op_shl   = 6'b001011,
    op_xor   = 6'b001100,
    op_test  = 6'b001101,
    op_cmp   = 6'b001110,
    op_addi  = 6'b010001,
    op_subi  = 6'b010010,
    op_noti  = 6'b010011,
    op_andi  = 6'b010100,
    op_ori   = 6'b010101,
    op_nandi = 6'b010110,
    op_nori  = 6'b010111,
    op_movi  = 6'b011000,
    op_sari  = 6'b011001,
    op_shri  = 6'b011010,
    op_shli  = 6'b011011,
    op_xori  = 6'b011100,
    op_testi = 6'b011101,
    op_cmpi  = 6'b011110,
    op_lw    = 6'b100000,
    op_la    = 6'b100001,
    op_sw    = 6'b100010,
    op_sa    = 6'b100011,
    op_jmp   = 6'b110000,
    op_je    = 6'b110001,
    op_jne   = 6'b110010,
    op_jl    = 6'b110011,
    op_jle   = 6'b110100,
    op_jg    = 6'b110101,
    op_jge   = 6'b110110,
    op_jz    = 6'b110111,
    op_jnz   = 6'b111000,
    op_jo    = 6'b111001,
    op_jr    = 6'b111010
  } opcode_e;

  // values line up with the opcode low bits.
  typedef enum logic [3:0] {
    alu_nop  = 4'd0,
    alu_add  = 4'd1,
    alu_sub  = 4'd2,
    alu_not  = 4'd3,
    alu_and  = 4'd4,
    alu_or   = 4'd5,
    alu_nand = 4'd6,
    alu_nor  = 4'd7,
    alu_mov  = 4'd8,
    alu_sar  = 4'd9,
    alu_shr  = 4'd10,
    alu_shl  = 4'd11,
    alu_xor  = 4'd12,
    alu_test = 4'd13,
    alu_cmp  = 4'd14
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_nop,
    mem_read,
    mem_write
  } mem_op_e;

  typedef enum logic [3:0] {
    jmp_nop,
    jmp_j,
    jmp_je,
    jmp_jne,
    jmp_jl,
    jmp_jle,
    jmp_jg,
    jmp_jge,
    jmp_jz,
    jmp_jnz,
    jmp_jo,
    jmp_jr
  } jmp_op_e;

  typedef struct packed {
    opcode_e                opcode;
    logic [reg_idx_w-1:0]   rd;
    logic [reg_idx_w-1:0]   rs;
    logic [reg_idx_w-1:0]   rt;
    logic [data_w-1:0]      imm;
  } instr_t;

  typedef struct packed {
    logic    reg_dst;      // 1 selects rd, else rt.
    logic    alu_src;      // 1 selects imm as operand b.
    logic    mem_to_reg;
    logic    reg_write;
    logic    address_src;  // 1 addresses memory by imm alone.
    alu_op_e alu_op;
    mem_op_e mem_op;
    jmp_op_e jop;
    logic    flag_write;
  } ctrl_t;

  typedef struct packed {
    logic zero;
    logic sign;
    logic carry;
    logic overflow;
  } flags_t;

  typedef struct packed {
    logic                 valid;
    logic [data_w-1:0]    pc;
    logic [data_w-1:0]    next_pc;
    logic                 reg_write;
    logic [reg_idx_w-1:0] wr_reg;
    logic [data_w-1:0]    wr_data;
    logic                 mem_write;
    logic [data_w-1:0]    mem_addr;
    logic [data_w-1:0]    mem_data;
    logic                 taken;
    flags_t               flags;     // value after the instruction.
  } retire_t;

endpackage

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_mem (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [core_pkg::data_w-1:0] addr,
  input  logic                        we,
  input  logic [core_pkg::data_w-1:0] wdata,
  output logic [core_pkg::data_w-1:0] rdata
);
  import core_pkg::*;

  logic [data_w-1:0]     words [mem_depth];
  logic [mem_addr_w-1:0] idx;

  assign idx   = addr[mem_addr_w-1:0];  // upper address bits ignored.
  assign rdata = words[idx];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < mem_depth; i++) begin
        words[i] <= '0;
      end
    end else if (we) begin
      words[idx] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/exec_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_core (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  core_pkg::instr_t  in_instr,
  output logic              credit_return,
  output core_pkg::retire_t retire
);
  import core_pkg::*;

  logic                 issue;
  instr_t               instr;
  ctrl_t                ctrl;
  logic [data_w-1:0]    rs_data;
  logic [data_w-1:0]    rt_data;
  logic [data_w-1:0]    alu_b;
  logic [data_w-1:0]    alu_result;
  flags_t               alu_flags;
  flags_t               flags_next;
  logic [reg_idx_w-1:0] wr_reg;
  logic [data_w-1:0]    wr_data;
  logic [data_w-1:0]    mem_addr;
  logic [data_w-1:0]    mem_rdata;
  logic [data_w-1:0]    pc;
  logic [data_w-1:0]    next_pc;
  logic                 taken;

  // operand and destination muxes.
  assign alu_b    = ctrl.alu_src ? instr.imm : rt_data;
  assign wr_reg   = ctrl.reg_dst ? instr.rd : instr.rt;
  assign mem_addr = ctrl.address_src ? instr.imm : alu_result;

  // no stalls, the head issues as soon as it is there.
  instr_queue instr_queue_i (
    .clk, .arst_n, .in_valid, .in_instr,
    .pop(issue), .issue_valid(issue), .issue_instr(instr), .credit_return
  );

  control_unit control_unit_i (.opcode(instr.opcode), .ctrl);

  reg_file reg_file_i (
    .clk, .arst_n, .rs_addr(instr.rs), .rt_addr(instr.rt), .rs_data, .rt_data,
    .we(issue && ctrl.reg_write), .wr_addr(wr_reg), .wr_data
  );

  alu alu_i (.op(ctrl.alu_op), .a(rs_data), .b(alu_b), .result(alu_result), .flags(alu_flags));

  branch_unit branch_unit_i (
    .clk, .arst_n, .issue, .jop(ctrl.jop), .flag_write(ctrl.flag_write), .alu_flags,
    .target_imm(instr.imm), .rs_data, .pc, .next_pc, .taken, .flags(flags_next)
  );

  data_mem data_mem_i (
    .clk, .arst_n, .addr(mem_addr), .we(issue && (ctrl.mem_op == mem_write)),
    .wdata(rt_data), .rdata(mem_rdata)
  );

  retire_unit retire_unit_i (
    .clk, .arst_n, .issue, .ctrl, .alu_result, .mem_rdata, .wr_reg, .mem_addr,
    .mem_data(rt_data), .pc, .next_pc, .taken, .flags_next, .wr_data, .retire
  );

endmodule

`default_nettype wire

// ==== hw/instr_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_queue (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  input  core_pkg::instr_t in_instr,
  input  logic             pop,
  output logic             issue_valid,
  output core_pkg::instr_t issue_instr,
  output logic             credit_return
);
  import core_pkg::*;

  instr_t             slots [credits];
  logic [q_ptr_w-1:0] wr_ptr;
  logic [q_ptr_w-1:0] rd_ptr;
  logic [q_cnt_w-1:0] count;
  logic               push;
  logic               pull;

  // a push while full only happens if the sender ignores its credits.
  assign push          = in_valid && (count != q_cnt_w'(credits));
  assign pull          = pop && issue_valid;
  assign issue_valid   = (count != '0);
  assign issue_instr   = slots[rd_ptr];
  assign credit_return = pull;  // one credit back per issue.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == q_ptr_w'(credits - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pull) begin
        rd_ptr <= (rd_ptr == q_ptr_w'(credits - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + q_cnt_w'(push) - q_cnt_w'(pull);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      slots[wr_ptr] <= in_instr;
    end
  end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [core_pkg::reg_idx_w-1:0] rs_addr,
  input  logic [core_pkg::reg_idx_w-1:0] rt_addr,
  output logic [core_pkg::data_w-1:0]    rs_data,
  output logic [core_pkg::data_w-1:0]    rt_data,
  input  logic                           we,
  input  logic [core_pkg::reg_idx_w-1:0] wr_addr,
  input  logic [core_pkg::data_w-1:0]    wr_data
);
  import core_pkg::*;

  logic [data_w-1:0] regs [reg_n];

  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  // r0 is writable like any other.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < reg_n; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/retire_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module retire_unit (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           issue,
  input  core_pkg::ctrl_t                ctrl,
  input  logic [core_pkg::data_w-1:0]    alu_result,
  input  logic [core_pkg::data_w-1:0]    mem_rdata,
  input  logic [core_pkg::reg_idx_w-1:0] wr_reg,
  input  logic [core_pkg::data_w-1:0]    mem_addr,
  input  logic [core_pkg::data_w-1:0]    mem_data,
  input  logic [core_pkg::data_w-1:0]    pc,
  input  logic [core_pkg::data_w-1:0]    next_pc,
  input  logic                           taken,
  input  core_pkg::flags_t               flags_next,
  output logic [core_pkg::data_w-1:0]    wr_data,
  output core_pkg::retire_t              retire
);
  import core_pkg::*;

  retire_t rec_q;

  assign wr_data = ctrl.mem_to_reg ? mem_rdata : alu_result;
  assign retire  = rec_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rec_q <= '0;
    end else begin
      rec_q.valid <= issue;  // one cycle per issued instruction.
      if (issue) begin
        rec_q.pc        <= pc;
        rec_q.next_pc   <= next_pc;
        rec_q.reg_write <= ctrl.reg_write;
        rec_q.wr_reg    <= wr_reg;
        rec_q.wr_data   <= wr_data;
        rec_q.mem_write <= (ctrl.mem_op == mem_write);
        rec_q.mem_addr  <= mem_addr;
        rec_q.mem_data  <= mem_data;
        rec_q.taken     <= taken;
        rec_q.flags     <= flags_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and judge the result from the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module exec_core_tb -f tb.f \
  -o exec_core_tb || exit 1
./obj_dir/exec_core_tb > sim.log 2>&1
cat sim.log
grep -qx "TEST PASS" sim.log && exit 0 || exit 1

// ==== sim/exec_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_core_tb;
  import core_pkg::*;

  localparam logic [31:0] seed        = 32'h493d0489;
  localparam int          drain_limit = 4000;  // cycles per phase.

  logic    clk;
  logic    arst_n;
  logic    in_valid;
  instr_t  in_instr;
  logic    credit_return;
  retire_t retire;

  // reference model state.
  logic [data_w-1:0] m_regs [reg_n];
  logic [data_w-1:0] m_mem  [mem_depth];
  flags_t            m_flags;
  logic [data_w-1:0] m_pc;

  instr_t  pend_q    [$];  // waiting for a credit.
  string   pend_name [$];
  retire_t exp_q     [$];  // predicted records in push order.
  string   exp_name  [$];

  retire_t     exp_rec;
  retire_t     act_rec;
  string       chk_name;
  logic        chk_on;
  logic [31:0] rng;
  logic [31:0] pace_rng;
  logic        pace_on;
  logic        timed_out;
  int          avail;
  int          pushed;
  int          credit_count;
  int          retire_count;
  int          errors;

  exec_core exec_core_i (.clk, .arst_n, .in_valid, .in_instr, .credit_return, .retire);

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic instr_t make_instr(input opcode_e op, input logic [3:0] rd,
                                        input logic [3:0] rs, input logic [3:0] rt,
                                        input logic [15:0] imm);
    instr_t i;
    i.opcode = op;
    i.rd     = rd;
    i.rs     = rs;
    i.rt     = rt;
    i.imm    = imm;
    return i;
  endfunction

  // kind is the opcode's low four bits.
  task automatic alu_model(input logic [3:0] kind, input logic [15:0] a, input logic [15:0] b,
                           output logic [15:0] res, output flags_t f);
    int usum;  // unsigned sum gives the carry.
    int ssum;  // signed result gives the overflow.
    f   = '0;
    res = '0;
    case (kind)
      4'd1: begin  // add.
        usum       = int'(a) + int'(b);
        ssum       = int'($signed(a)) + int'($signed(b));
        res        = a + b;
        f.carry    = (usum > 65535);
        f.overflow = (ssum > 32767) || (ssum < -32768);
      end
      4'd2, 4'd14: begin  // sub and cmp with carry as borrow.
        ssum       = int'($signed(a)) - int'($signed(b));
        res        = a - b;
        f.carry    = (a < b);
        f.overflow = (ssum > 32767) || (ssum < -32768);
      end
      4'd3:        res = ~a;
      4'd4, 4'd13: res = a & b;  // and, test.
      4'd5:        res = a | b;
      4'd6:        res = ~(a & b);
      4'd7:        res = ~(a | b);
      4'd8:        res = b;
      4'd9:        res = $signed(a) >>> b[3:0];
      4'd10:       res = a >> b[3:0];
      4'd11:       res = a << b[3:0];
      4'd12:       res = a ^ b;
      default:     res = '0;
    endcase
    f.zero = (res == '0);
    f.sign = res[15];
  endtask

  function automatic logic jump_taken(input logic [3:0] k, input flags_t f);
    logic less;
    less = f.sign ^ f.overflow;
    case (k)
      4'd0, 4'd10: return 1'b1;  // jmp, jr.
      4'd1, 4'd7:  return f.zero;
      4'd2, 4'd8:  return !f.zero;
      4'd3:        return less;
      4'd4:        return less || f.zero;
      4'd5:        return !less && !f.zero;
      4'd6:        return !less;
      4'd9:        return f.overflow;
      default:     return 1'b0;
    endcase
  endfunction

  // runs one instruction on the model.
  task automatic predict(input instr_t ins, output retire_t rec);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    flags_t      f;
    logic [3:0]  k;
    k           = ins.opcode[3:0];
    a           = m_regs[ins.rs];
    rec         = '0;
    rec.valid   = 1'b1;
    rec.pc      = m_pc;
    rec.next_pc = m_pc + 16'd1;
    case (ins.opcode[5:4])
      2'b00, 2'b01: begin
        if (k != 4'd0 && k != 4'd15) begin
          b = ins.opcode[4] ? ins.imm : m_regs[ins.rt];
          alu_model(k, a, b, res, f);
          m_flags = f;
          if (k != 4'd13 && k != 4'd14) begin  // compares leave registers alone.
            rec.reg_write = 1'b1;
            rec.wr_reg    = ins.opcode[4] ? ins.rt : ins.rd;
            rec.wr_data   = res;
          end
        end
      end
      2'b10: begin
        if (ins.opcode[0]) begin
          addr = ins.imm;  // la, sa.
        end else begin
          alu_model(4'd1, a, ins.imm, addr, f);
          m_flags = f;
        end
        if (ins.opcode[1]) begin
          rec.mem_write         = 1'b1;
          rec.mem_addr          = addr;
          rec.mem_data          = m_regs[ins.rt];
          m_mem[addr[7:0]]      = m_regs[ins.rt];
        end else begin
          rec.reg_write = 1'b1;
          rec.wr_reg    = ins.rt;
          rec.wr_data   = m_mem[addr[7:0]];
        end
      end
      default: begin
        rec.taken = jump_taken(k, m_flags);
        if (rec.taken) begin
          rec.next_pc = (k == 4'd10) ? a : ins.imm;
        end
      end
    endcase
    if (rec.reg_write) begin
      m_regs[rec.wr_reg] = rec.wr_data;
    end
    rec.flags = m_flags;
    m_pc      = rec.next_pc;
  endtask

  function automatic logic [47:0] reg_view(input retire_t r);
    return r.reg_write ? {27'h0, r.reg_write, r.wr_reg, r.wr_data} : 48'h0;
  endfunction

  function automatic logic [47:0] mem_view(input retire_t r);
    return r.mem_write ? {15'h0, r.mem_write, r.mem_addr, r.mem_data} : 48'h0;
  endfunction

  task automatic report_mismatch(input string field, input logic [47:0] exp,
                                 input logic [47:0] act);
    errors++;
    $display("FAILED %s %s: expected %0h, actual %0h", chk_name, field, exp, act);
  endtask

  assert property (@(posedge clk) disable iff (!arst_n) chk_on |-> act_rec.pc == exp_rec.pc)
    else report_mismatch("pc", 48'(exp_rec.pc), 48'(act_rec.pc));
  assert property (@(posedge clk) disable iff (!arst_n)
                   chk_on |-> {act_rec.next_pc, act_rec.taken} == {exp_rec.next_pc, exp_rec.taken})
    else report_mismatch("next_pc/taken", 48'({exp_rec.next_pc, exp_rec.taken}),
                         48'({act_rec.next_pc, act_rec.taken}));
  assert property (@(posedge clk) disable iff (!arst_n) chk_on |-> act_rec.flags == exp_rec.flags)
    else report_mismatch("flags", 48'(exp_rec.flags), 48'(act_rec.flags));
  assert property (@(posedge clk) disable iff (!arst_n)
                   chk_on |-> reg_view(act_rec) == reg_view(exp_rec))
    else report_mismatch("reg write", reg_view(exp_rec), reg_view(act_rec));
  assert property (@(posedge clk) disable iff (!arst_n)
                   chk_on |-> mem_view(act_rec) == mem_view(exp_rec))
    else report_mismatch("mem write", mem_view(exp_rec), mem_view(act_rec));

  // sender spends one credit per push.
  always @(negedge clk) begin : drive
    retire_t rec;
    logic    go;
    in_valid = 1'b0;
    if (arst_n && pend_q.size() != 0 && avail > 0) begin
      pace_rng = xorshift(pace_rng);
      go       = !pace_on || (pace_rng[1:0] != 2'b00);  // random gaps.
      if (go) begin
        in_instr = pend_q.pop_front();
        in_valid = 1'b1;
        predict(in_instr, rec);
        exp_q.push_back(rec);
        exp_name.push_back(pend_name.pop_front());
        avail--;
        pushed++;
      end
    end
    // a pulse in this cycle frees a slot only after the edge.
    if (arst_n && credit_return) begin
      avail++;
      credit_count++;
    end
    assert (avail >= 0 && avail <= credits)
      else begin
        errors++;
        $display("sender credit count out of range: %0d", avail);
      end
  end

  always @(negedge clk) begin : observe
    chk_on = 1'b0;
    if (arst_n && retire.valid) begin
      if (retire_count == 0) begin
        assert (retire.pc == 16'h0)
          else begin
            errors++;
            $display("FAILED first_retire pc: expected 0, actual %0h", retire.pc);
          end
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("a retire record appeared with no instruction outstanding");
      end else begin
        act_rec  = retire;
        exp_rec  = exp_q.pop_front();
        chk_name = exp_name.pop_front();
        chk_on   = 1'b1;
      end
      retire_count++;
    end
  end

  task automatic check_idle(input string phase);
    assert (!retire.valid && !credit_return)
      else begin
        errors++;
        $display("retire.valid or credit_return went high during %s", phase);
      end
  endtask

  task automatic queue_instr(input instr_t ins, input string name);
    pend_q.push_back(ins);
    pend_name.push_back(name);
  endtask

  task automatic wait_drain(input string phase);
    int cycles;
    cycles = 0;
    while (!timed_out && (pend_q.size() != 0 || exp_q.size() != 0 || avail != credits)) begin
      @(negedge clk);
      cycles++;
      if (cycles > drain_limit) begin
        timed_out = 1'b1;
        $display("timeout: %s phase did not drain within %0d cycles", phase, drain_limit);
      end
    end
    repeat (2) @(negedge clk);  // last record still needs its edge.
  endtask

  task automatic alu_checks();
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd14, 16'h8001), "alu_i");
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd15, 16'h0003), "alu_i");
    for (int k = 1; k <= 14; k++) begin
      queue_instr(make_instr(opcode_e'({2'b00, 4'(k)}), 4'(k), 4'd14, 4'd15, 16'h0), "alu_r");
    end
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd14, 16'h7ffe), "alu_i");
    for (int k = 1; k <= 14; k++) begin
      queue_instr(make_instr(opcode_e'({2'b01, 4'(k)}), 4'd0, 4'd14, 4'(k), 16'h0002), "alu_i");
    end
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd1, 16'hffff), "alu_i");
    queue_instr(make_instr(op_addi, 4'd0, 4'd1, 4'd2, 16'h0001), "alu_i");  // carry, zero.
    queue_instr(make_instr(op_cmpi, 4'd0, 4'd1, 4'd0, 16'hffff), "alu_i");
    wait_drain("alu");
  endtask

  task automatic mem_checks();
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd1, 16'h0040), "mem");
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd2, 16'hbeef), "mem");
    queue_instr(make_instr(op_sw, 4'd0, 4'd1, 4'd2, 16'h0005), "mem");  // rs+imm is 0x45.
    queue_instr(make_instr(op_la, 4'd0, 4'd0, 4'd3, 16'h0045), "mem");
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd4, 16'h1234), "mem");
    queue_instr(make_instr(op_sa, 4'd0, 4'd0, 4'd4, 16'h0080), "mem");
    queue_instr(make_instr(op_lw, 4'd0, 4'd1, 4'd5, 16'h0040), "mem");
    queue_instr(make_instr(op_la, 4'd0, 4'd0, 4'd6, 16'h0145), "mem");  // upper bits dropped.
    wait_drain("mem");
  endtask

  task automatic jump_checks();
    logic [15:0] cmp_val [4];
    logic [3:0]  cmp_reg [4];
    // equal, less, greater, overflow.
    cmp_val = '{16'h0005, 16'h0007, 16'h0003, 16'h0001};
    cmp_reg = '{4'd1, 4'd1, 4'd1, 4'd2};
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd1, 16'h0005), "jump");
    queue_instr(make_instr(op_movi, 4'd0, 4'd0, 4'd2, 16'h8000), "jump");
    for (int s = 0; s < 4; s++) begin
      queue_instr(make_instr(op_cmpi, 4'd0, cmp_reg[s], 4'd0, cmp_val[s]), "jump");
      for (int k = 0; k <= 10; k++) begin
        queue_instr(make_instr(opcode_e'({2'b11, 4'(k)}), 4'd0, 4'd1, 4'd0,
                               16'h0100 + 16'(k)), "jump");
      end
    end
    wait_drain("jump");
  endtask

  task automatic burst_check();
    pace_on = 1'b0;  // back to back.
    for (int i = 0; i < credits; i++) begin
      queue_instr(make_instr(op_addi, 4'd0, 4'(i), 4'(i + 1), 16'(i + 1)), "burst");
    end
    wait_drain("burst");
  endtask

  function automatic instr_t random_instr();
    logic [31:0] r;
    logic [31:0] f;
    logic [5:0]  op;
    logic [15:0] imm;
    r = next_rand();
    f = next_rand();
    case (r[2:0])
      3'd0, 3'd1, 3'd2: op = {2'b00, 4'(1 + (r[31:8] % 14))};
      3'd3, 3'd4:       op = {2'b01, 4'(1 + (r[31:8] % 14))};
      3'd5:             op = {4'b1000, r[4:3]};
      default:          op = {2'b11, 4'(r[31:8] % 11)};
    endcase
    imm = (op[5:4] == 2'b10) ? {8'h0, f[23:16]} : f[31:16];  // small memory window.
    return make_instr(opcode_e'(op), f[3:0], f[7:4], f[11:8], imm);
  endfunction

  task automatic random_program(input int n);
    pace_on = 1'b1;
    for (int i = 0; i < n; i++) begin
      queue_instr(random_instr(), "random");
    end
    wait_drain("random");
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_instr     = '0;
    rng          = seed;
    pace_rng     = xorshift(~seed);
    pace_on      = 1'b0;
    timed_out    = 1'b0;
    chk_on       = 1'b0;
    avail        = credits;
    pushed       = 0;
    credit_count = 0;
    retire_count = 0;
    errors       = 0;
    m_flags      = '0;
    m_pc         = '0;
    for (int i = 0; i < reg_n; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < mem_depth; i++) begin
      m_mem[i] = '0;
    end

    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_idle("reset");
    end
    arst_n = 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_idle("idle after reset");
    end

    alu_checks();
    if (!timed_out) mem_checks();
    if (!timed_out) jump_checks();
    if (!timed_out) burst_check();
    if (!timed_out) random_program(400);

    if (credit_count != retire_count || pushed != retire_count) begin
      errors++;
      $display("credit pulses (%0d), pushes (%0d) and retires (%0d) do not match",
               credit_count, pushed, retire_count);
    end
    $display("pushed %0d, retired %0d, credits returned %0d, errors %0d, timeouts %0d",
             pushed, retire_count, credit_count, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/core_pkg.sv
hw/instr_queue.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/data_mem.sv
hw/retire_unit.sv
hw/exec_core.sv
sim/exec_core_tb.sv
